// ==== logic/l1_refill_pkg.sv ====
// Constants, state encoding, address and line views, and port records of the refill controller
package l1_refill_pkg;

  //====================================================================
  // Widths and line geometry
  //====================================================================
  // Stored PC bits, bit 0 is implied
  localparam int PC_WIDTH       = 39;
  localparam int LINE_BEATS     = 4;
  localparam int LINE_HALFWORDS = 8;

  // Beat position now lives in a counter, not in the state
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    REQ     = 2'd1,
    WFD     = 2'd2,
    INV_WFD = 2'd3
  } refill_state_e;

  // Fetch address split into cache fields
  typedef struct packed {
    logic [27:0] tag;
    logic [5:0]  set;
    logic [1:0]  beat;
    logic [2:0]  offset;
  } refill_pc_t;

  // One refill beat, seen flat or as halfwords
  typedef union packed {
    logic [127:0]                         flat;
    logic [LINE_HALFWORDS-1:0][15:0]      hw;
  } refill_line_u;

  typedef struct packed {
    logic tsize;
    logic cacheable;
    logic bufferable;
    logic supv_mode;
    logic machine_mode;
    logic secure;
  } refill_attr_t;

  //====================================================================
  // Port records
  //====================================================================
  // Request toward the bus interface
  typedef struct packed {
    logic              req;
    refill_attr_t      attr;
    logic [PC_WIDTH:0] ppc;
    logic [PC_WIDTH:0] vpc;
  } ipb_req_t;

  // Write port of the cache arrays
  typedef struct packed {
    logic         wr;
    logic         first;
    logic         last;
    refill_pc_t   index;
    logic [27:0]  ptag;
    logic [127:0] inst_data;
  } icache_wr_t;

  // Bypass record toward the fetch datapath
  typedef struct packed {
    logic         refill_on;
    logic         acc_err;
    logic [28:0]  tag_data;
    logic [127:0] inst_data;
  } ifdp_refill_t;

endpackage

// ==== logic/refill_fsm.sv ====
// Refill state machine with its decoded control strobes
module refill_fsm (
  input  logic                          l1_refill_clk,
  input  logic                          cpurst_b,
  input  logic                          miss_req,
  input  logic                          grnt,
  input  logic                          chgflw,
  input  logic                          data_vld,
  input  logic                          trans_err,
  input  logic                          last_beat,
  input  logic [1:0]                    beat_idx,
  output l1_refill_pkg::refill_state_e  state,
  output logic                          refill_start,
  output logic                          beat_clear,
  output logic                          beat_adv,
  output logic                          index_inc,
  output logic                          wfd_data,
  output logic                          wfd_err,
  output logic                          ipb_req,
  output logic                          refill_on,
  output logic                          busy,
  output logic                          idle,
  output logic                          reissue
);

  l1_refill_pkg::refill_state_e next_state;
  logic                         in_wfd;
  logic                         in_inv_wfd;
  logic                         beat;

  //====================================================================
  // State register
  //====================================================================
  always_ff @(posedge l1_refill_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      state <= l1_refill_pkg::IDLE;
    else
      state <= next_state;
  end

  assign in_wfd     = (state == l1_refill_pkg::WFD);
  assign in_inv_wfd = (state == l1_refill_pkg::INV_WFD);

  // Bus returns a beat, good or failed
  assign beat = (in_wfd || in_inv_wfd) && (data_vld || trans_err);

  always_comb
  begin
    next_state = state;
    case (state)
      l1_refill_pkg::IDLE:
        if (miss_req)
          next_state = l1_refill_pkg::REQ;
      l1_refill_pkg::REQ:
        // Flow change before grant simply withdraws the request
        if (chgflw && !grnt)
          next_state = l1_refill_pkg::IDLE;
        else if (grnt && !chgflw)
          next_state = l1_refill_pkg::WFD;
        else if (grnt && chgflw)
          next_state = l1_refill_pkg::INV_WFD;
      l1_refill_pkg::WFD:
        if (beat && last_beat)
          next_state = l1_refill_pkg::IDLE;
        else if (trans_err)
          next_state = l1_refill_pkg::INV_WFD;
        // Only before the first beat may a flow change spoil the line
        else if (!beat && chgflw && (beat_idx == 2'd0))
          next_state = l1_refill_pkg::INV_WFD;
      l1_refill_pkg::INV_WFD:
        if (beat && last_beat)
          next_state = l1_refill_pkg::IDLE;
      default:
        next_state = l1_refill_pkg::IDLE;
    endcase
  end

  //====================================================================
  // Control strobes
  //====================================================================
  assign refill_start = miss_req && (state == l1_refill_pkg::IDLE);
  assign beat_clear   = grnt && (state == l1_refill_pkg::REQ);
  assign beat_adv     = beat;
  assign index_inc    = beat && in_wfd && !last_beat;

  assign wfd_data = in_wfd && data_vld;
  assign wfd_err  = in_wfd && trans_err;

  assign ipb_req   = (state == l1_refill_pkg::REQ);
  assign refill_on = (state == l1_refill_pkg::REQ) || in_wfd;
  assign busy      = (state != l1_refill_pkg::IDLE);
  assign idle      = (state == l1_refill_pkg::IDLE);

  // Fetch restarts after a complete line or on a bus error
  assign reissue = (wfd_data && last_beat) || wfd_err;

endmodule

// ==== logic/refill_beat_counter.sv ====
// Beat counter of a refill transfer and its last-beat flag
module refill_beat_counter (
  input  logic       l1_refill_clk,
  input  logic       cpurst_b,
  input  logic       beat_clear,
  input  logic       beat_adv,
  input  logic       tsize,
  output logic [1:0] beat_idx,
  output logic       last_beat
);

  localparam logic [1:0] FINAL_BEAT = 2'(l1_refill_pkg::LINE_BEATS - 1);

  // Grant restarts the count, each beat moves it on
  always_ff @(posedge l1_refill_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      beat_idx <= 2'd0;
    else if (beat_clear)
      beat_idx <= 2'd0;
    else if (beat_adv)
      beat_idx <= beat_idx + 2'd1;
  end

  // A single-beat transfer ends on its first beat
  assign last_beat = (beat_idx == FINAL_BEAT) || !tsize;

endmodule

// ==== logic/refill_addr_regs.sv ====
// Virtual and physical refill PC registers with beat stepping, plus captured attributes
module refill_addr_regs (
  input  logic                        l1_refill_clk,
  input  logic                        cpurst_b,
  input  logic                        refill_start,
  input  logic                        index_inc,
  input  l1_refill_pkg::refill_pc_t   vpc,
  input  l1_refill_pkg::refill_pc_t   ppc,
  input  l1_refill_pkg::refill_attr_t req_attr,
  output l1_refill_pkg::refill_pc_t   pc_v,
  output l1_refill_pkg::refill_pc_t   pc_p,
  output l1_refill_pkg::refill_attr_t attr
);

  // Next beat of the same line, aligned to its start
  function automatic l1_refill_pkg::refill_pc_t beat_step(
    input l1_refill_pkg::refill_pc_t pc
  );
    l1_refill_pkg::refill_pc_t nxt;
    nxt        = pc;
    nxt.beat   = pc.beat + 2'd1;
    nxt.offset = 3'd0;
    return nxt;
  endfunction

  //====================================================================
  // Transfer attributes
  //====================================================================
  always_ff @(posedge l1_refill_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      attr <= '0;
    else if (refill_start)
      attr <= req_attr;
  end

  //====================================================================
  // Fetch address registers
  //====================================================================
  // Both PCs step together so index and ptag stay on the same beat
  always_ff @(posedge l1_refill_clk)
  begin
    if (refill_start)
    begin
      pc_v <= vpc;
      pc_p <= ppc;
    end
    else if (index_inc)
    begin
      pc_v <= beat_step(pc_v);
      pc_p <= beat_step(pc_p);
    end
  end

endmodule

// ==== logic/refill_data_path.sv ====
// Halfword reordering of refill data and assembly of cache write and fetch records
module refill_data_path (
  input  logic [127:0]                rdata,
  input  l1_refill_pkg::refill_pc_t   pc_v,
  input  l1_refill_pkg::refill_pc_t   pc_p,
  input  l1_refill_pkg::refill_attr_t attr,
  input  logic                        wfd_data,
  input  logic                        wfd_err,
  input  logic [1:0]                  beat_idx,
  input  logic                        last_beat,
  input  logic                        refill_on,
  output l1_refill_pkg::icache_wr_t   icache_wr,
  output l1_refill_pkg::ifdp_refill_t ifdp
);

  l1_refill_pkg::refill_line_u raw_line;
  l1_refill_pkg::refill_line_u swap_line;
  logic                        line_wr;

  //====================================================================
  // Halfword order
  //====================================================================
  // Bus puts the lowest halfword first, the arrays want it on top
  always_comb
  begin
    raw_line.flat = rdata;
    for (int k = 0; k < l1_refill_pkg::LINE_HALFWORDS; k++)
      swap_line.hw[k] = raw_line.hw[l1_refill_pkg::LINE_HALFWORDS - 1 - k];
  end

  // Only full-line transfers are written into the arrays
  assign line_wr = wfd_data && attr.tsize;

  always_comb
  begin
    icache_wr.wr        = line_wr;
    icache_wr.first     = line_wr && (beat_idx == 2'd0);
    icache_wr.last      = line_wr && last_beat;
    icache_wr.index     = pc_v;
    icache_wr.ptag      = pc_p.tag;
    icache_wr.inst_data = swap_line.flat;
  end

  // Fetch bypass, tag valid rides on top of the tag
  always_comb
  begin
    ifdp.refill_on = refill_on;
    ifdp.acc_err   = wfd_err;
    ifdp.tag_data  = {wfd_data, pc_p.tag};
    ifdp.inst_data = swap_line.flat;
  end

endmodule

// ==== logic/l1_refill.sv ====
// Top level of the instruction cache refill controller
module l1_refill (
  input  logic                        l1_refill_clk,
  input  logic                        cpurst_b,
  // Miss request from the fetch stage
  input  logic                        miss_req,
  input  l1_refill_pkg::refill_pc_t   vpc,
  input  l1_refill_pkg::refill_pc_t   ppc,
  input  l1_refill_pkg::refill_attr_t req_attr,
  // Bus interface
  input  logic                        grnt,
  input  logic                        data_vld,
  input  logic                        trans_err,
  input  logic [127:0]                rdata,
  input  logic                        chgflw,
  output l1_refill_pkg::ipb_req_t     ipb,
  output l1_refill_pkg::icache_wr_t   icache_wr,
  output l1_refill_pkg::ifdp_refill_t ifdp,
  output logic                        reissue,
  output logic                        refill_on,
  output logic                        ipctrl_busy,
  output logic                        idle
);

  l1_refill_pkg::refill_pc_t    pc_v;
  l1_refill_pkg::refill_pc_t    pc_p;
  l1_refill_pkg::refill_attr_t  attr;
  logic                         refill_start;
  logic                         beat_clear;
  logic                         beat_adv;
  logic                         index_inc;
  logic                         wfd_data;
  logic                         wfd_err;
  logic                         ipb_req;
  logic [1:0]                   beat_idx;
  logic                         last_beat;

  //====================================================================
  // Control
  //====================================================================
  refill_fsm u_fsm (
    .l1_refill_clk (l1_refill_clk),
    .cpurst_b      (cpurst_b),
    .miss_req      (miss_req),
    .grnt          (grnt),
    .chgflw        (chgflw),
    .data_vld      (data_vld),
    .trans_err     (trans_err),
    .last_beat     (last_beat),
    .beat_idx      (beat_idx),
    .state         (),
    .refill_start  (refill_start),
    .beat_clear    (beat_clear),
    .beat_adv      (beat_adv),
    .index_inc     (index_inc),
    .wfd_data      (wfd_data),
    .wfd_err       (wfd_err),
    .ipb_req       (ipb_req),
    .refill_on     (refill_on),
    .busy          (ipctrl_busy),
    .idle          (idle),
    .reissue       (reissue)
  );

  refill_beat_counter u_beat_cnt (
    .l1_refill_clk (l1_refill_clk),
    .cpurst_b      (cpurst_b),
    .beat_clear    (beat_clear),
    .beat_adv      (beat_adv),
    .tsize         (attr.tsize),
    .beat_idx      (beat_idx),
    .last_beat     (last_beat)
  );

  //====================================================================
  // Address and data
  //====================================================================
  refill_addr_regs u_addr (
    .l1_refill_clk (l1_refill_clk),
    .cpurst_b      (cpurst_b),
    .refill_start  (refill_start),
    .index_inc     (index_inc),
    .vpc           (vpc),
    .ppc           (ppc),
    .req_attr      (req_attr),
    .pc_v          (pc_v),
    .pc_p          (pc_p),
    .attr          (attr)
  );

  refill_data_path u_data (
    .rdata     (rdata),
    .pc_v      (pc_v),
    .pc_p      (pc_p),
    .attr      (attr),
    .wfd_data  (wfd_data),
    .wfd_err   (wfd_err),
    .beat_idx  (beat_idx),
    .last_beat (last_beat),
    .refill_on (refill_on),
    .icache_wr (icache_wr),
    .ifdp      (ifdp)
  );

  // Bus addresses carry the implied halfword bit as zero
  always_comb
  begin
    ipb.req  = ipb_req;
    ipb.attr = attr;
    ipb.ppc  = {pc_p, 1'b0};
    ipb.vpc  = {pc_v, 1'b0};
  end

endmodule

// ==== bench/l1_refill_checker.sv ====
// Bound assertion module with shadow address copies and beat tracking for the refill controller
module l1_refill_checker (
  input logic                        l1_refill_clk,
  input logic                        cpurst_b,
  input logic                        miss_req,
  input l1_refill_pkg::refill_pc_t   vpc,
  input l1_refill_pkg::refill_pc_t   ppc,
  input l1_refill_pkg::refill_attr_t req_attr,
  input logic                        grnt,
  input logic                        data_vld,
  input logic                        trans_err,
  input logic [127:0]                rdata,
  input logic                        chgflw,
  input l1_refill_pkg::ipb_req_t     ipb,
  input l1_refill_pkg::icache_wr_t   icache_wr,
  input l1_refill_pkg::ifdp_refill_t ifdp,
  input logic                        reissue,
  input logic                        refill_on,
  input logic                        ipctrl_busy,
  input logic                        idle
);
  timeunit 1ns;
  timeprecision 1ns;

  string                       test_name = "reset";
  int                          err_count = 0;
  l1_refill_pkg::refill_pc_t   shadow_vpc;
  l1_refill_pkg::refill_pc_t   shadow_ppc;
  l1_refill_pkg::refill_attr_t shadow_attr;
  logic [2:0]                  beat_num;
  logic                        err_seen;
  logic                        inv_xfer;
  logic                        beat_now;
  logic                        wfd_beat;
  l1_refill_pkg::icache_wr_t   exp_wr;

  // Busy but past the request, with the bus returning something
  assign beat_now = ipctrl_busy && !ipb.req && (data_vld || trans_err);

  // Beat of a transfer that is still valid
  assign wfd_beat = beat_now && !inv_xfer && !err_seen;

  //======================================================================
  // Shadow state
  //======================================================================
  always_ff @(posedge l1_refill_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      shadow_vpc  <= '0;
      shadow_ppc  <= '0;
      shadow_attr <= '0;
      beat_num    <= 3'd0;
      err_seen    <= 1'b0;
      inv_xfer    <= 1'b0;
    end
    else
    begin
      if (miss_req && idle)
      begin
        shadow_vpc  <= vpc;
        shadow_ppc  <= ppc;
        shadow_attr <= req_attr;
      end
      if (ipb.req && grnt)
        beat_num <= 3'd0;
      else if (beat_now)
        beat_num <= beat_num + 3'd1;
      err_seen <= !idle && (err_seen || (wfd_beat && trans_err));
      inv_xfer <= !idle && (inv_xfer || (ipb.req && grnt && chgflw));
    end
  end

  // Expected cache write for the current beat
  always_comb
  begin
    exp_wr.wr         = 1'b1;
    exp_wr.first      = (beat_num == 3'd0);
    exp_wr.last       = (beat_num == 3'd3);
    exp_wr.index      = shadow_vpc;
    exp_wr.index.beat = shadow_vpc.beat + beat_num[1:0];
    if (beat_num != 3'd0)
      exp_wr.index.offset = 3'd0;
    exp_wr.ptag       = shadow_ppc.tag;
    // Halfword k of the line is halfword 7-k of the bus word
    for (int k = 0; k < 8; k++)
      exp_wr.inst_data[16*k +: 16] = rdata[16*(7-k) +: 16];
  end

  //======================================================================
  // Assertions
  //======================================================================
  req_after_miss: assert property (@(posedge l1_refill_clk) disable iff (!cpurst_b)
    miss_req && idle |=> ipb == {1'b1, shadow_attr, shadow_ppc, 1'b0, shadow_vpc, 1'b0})
    else
    begin
      err_count++;
      $error("mismatch %s: ipb expected %h actual %h", test_name,
             $sampled({1'b1, shadow_attr, shadow_ppc, 1'b0, shadow_vpc, 1'b0}),
             $sampled(ipb));
    end

  line_write: assert property (@(posedge l1_refill_clk) disable iff (!cpurst_b)
    (wfd_beat && data_vld && shadow_attr.tsize) || icache_wr.wr |-> icache_wr == exp_wr)
    else
    begin
      err_count++;
      $error("mismatch %s: icache_wr expected %h actual %h", test_name,
             $sampled(exp_wr), $sampled(icache_wr));
    end

  reissue_on_fourth: assert property (@(posedge l1_refill_clk) disable iff (!cpurst_b)
    wfd_beat && data_vld && shadow_attr.tsize |-> reissue == (beat_num == 3'd3))
    else
    begin
      err_count++;
      $error("mismatch %s: reissue expected %0b actual %0b", test_name,
             $sampled(beat_num == 3'd3), $sampled(reissue));
    end

  fetch_record: assert property (@(posedge l1_refill_clk) disable iff (!cpurst_b)
    wfd_beat && data_vld |-> refill_on && ifdp.refill_on &&
      ifdp.tag_data == {1'b1, shadow_ppc.tag} && ifdp.inst_data == exp_wr.inst_data)
    else
    begin
      err_count++;
      $error("mismatch %s: fetch record expected %h actual %h", test_name,
             $sampled({2'b11, 1'b1, shadow_ppc.tag, exp_wr.inst_data}),
             $sampled({refill_on, ifdp.refill_on, ifdp.tag_data, ifdp.inst_data}));
    end

  idle_after_last: assert property (@(posedge l1_refill_clk) disable iff (!cpurst_b)
    beat_now && (beat_num == 3'd3 || !shadow_attr.tsize) |=> idle)
    else
    begin
      err_count++;
      $error("mismatch %s: idle expected 1 actual %0b", test_name, $sampled(idle));
    end

  busy_flag: assert property (@(posedge l1_refill_clk) disable iff (!cpurst_b)
    ipctrl_busy == !idle)
    else
    begin
      err_count++;
      $error("mismatch %s: ipctrl_busy expected %0b actual %0b", test_name,
             $sampled(!idle), $sampled(ipctrl_busy));
    end

  single_beat: assert property (@(posedge l1_refill_clk) disable iff (!cpurst_b)
    wfd_beat && data_vld && !shadow_attr.tsize |-> reissue && !icache_wr.wr)
    else
    begin
      err_count++;
      $error("mismatch %s: reissue and wr expected 10 actual %b", test_name,
             $sampled({reissue, icache_wr.wr}));
    end

  bus_error: assert property (@(posedge l1_refill_clk) disable iff (!cpurst_b)
    wfd_beat && trans_err |-> ifdp.acc_err && reissue)
    else
    begin
      err_count++;
      $error("mismatch %s: acc_err and reissue expected 11 actual %b", test_name,
             $sampled({ifdp.acc_err, reissue}));
    end

  quiet_after_abort: assert property (@(posedge l1_refill_clk) disable iff (!cpurst_b)
    err_seen || inv_xfer |-> !icache_wr.wr && !reissue && !refill_on)
    else
    begin
      err_count++;
      $error("mismatch %s: wr, reissue and refill_on expected 000 actual %b", test_name,
             $sampled({icache_wr.wr, reissue, refill_on}));
    end

  cancel_in_req: assert property (@(posedge l1_refill_clk) disable iff (!cpurst_b)
    ipb.req && chgflw && !grnt |=> !ipb.req && idle)
    else
    begin
      err_count++;
      $error("mismatch %s: req and idle expected 01 actual %b", test_name,
             $sampled({ipb.req, idle}));
    end

endmodule

bind l1_refill l1_refill_checker u_checker (.*);

// ==== bench/tb_l1_refill.sv ====
// Testbench of the refill controller with clock, reset, refill scenarios, watchdog and verdict
module tb_l1_refill;
  timeunit 1ns;
  timeprecision 1ns;

  localparam int RESET_CYCLES = 16;
  localparam int NUM_TESTS    = 6;
  // Longest test, four beats with gaps plus request and drain
  localparam int TEST_LEN     = 16;
  localparam int WAIT_LIMIT   = 20;
  localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_TESTS * TEST_LEN) * 2 * 100;

  logic                        l1_refill_clk;
  logic                        cpurst_b;
  logic                        miss_req;
  l1_refill_pkg::refill_pc_t   vpc;
  l1_refill_pkg::refill_pc_t   ppc;
  l1_refill_pkg::refill_attr_t req_attr;
  logic                        grnt;
  logic                        data_vld;
  logic                        trans_err;
  logic [127:0]                rdata;
  logic                        chgflw;
  l1_refill_pkg::ipb_req_t     ipb;
  l1_refill_pkg::icache_wr_t   icache_wr;
  l1_refill_pkg::ifdp_refill_t ifdp;
  logic                        reissue;
  logic                        refill_on;
  logic                        ipctrl_busy;
  logic                        idle;

  integer seed = 32'h2fd1d086;
  int     fail_count = 0;
  int     test_count = 0;
  int     tests_failed = 0;
  int     errs_before = 0;

  l1_refill DUT (.*);

  initial
  begin
    l1_refill_clk = 1'b0;
    forever
      #50 l1_refill_clk = ~l1_refill_clk;
  end

  task automatic step(input int n);
    repeat (n) @(posedge l1_refill_clk);
    #5;
  endtask

  task automatic wait_until(input logic want_idle, input string what);
    int cycles;
    cycles = 0;
    while (((want_idle ? idle : ipb.req) == 1'b0) && (cycles < WAIT_LIMIT))
    begin
      step(1);
      cycles++;
    end
    if ((want_idle ? idle : ipb.req) == 1'b0)
    begin
      $display("timeout waiting for %s in test %s", what, DUT.u_checker.test_name);
      fail_count++;
    end
  endtask

  task automatic start_miss(input logic tsize);
    logic [63:0] rnd;
    rnd      = {$random(seed), $random(seed)};
    vpc      = rnd[38:0];
    rnd      = {$random(seed), $random(seed)};
    ppc      = rnd[38:0];
    req_attr = {tsize, rnd[63:59]};
    miss_req = 1'b1;
    step(1);
    miss_req = 1'b0;
    wait_until(1'b0, "bus request");
  endtask

  task automatic bus_response(input logic g, input logic c);
    grnt   = g;
    chgflw = c;
    step(1);
    grnt   = 1'b0;
    chgflw = 1'b0;
  endtask

  // Beats with random gaps, one beat may carry a bus error
  task automatic send_beats(input int n, input int err_beat);
    for (int i = 0; i < n; i++)
    begin
      if (($random(seed) & 1) != 0)
        step(1);
      data_vld  = (i != err_beat);
      trans_err = (i == err_beat);
      rdata     = {$random(seed), $random(seed), $random(seed), $random(seed)};
      step(1);
      data_vld  = 1'b0;
      trans_err = 1'b0;
    end
  endtask

  task automatic end_test();
    int errs;
    wait_until(1'b1, "idle");
    // One more edge so checks that look one cycle ahead have resolved
    step(1);
    errs = DUT.u_checker.err_count + fail_count - errs_before;
    errs_before = errs_before + errs;
    test_count++;
    if (errs != 0)
      tests_failed++;
    $display("test %s: %s", DUT.u_checker.test_name, (errs == 0) ? "ok" : "failed");
  endtask

  initial
  begin
    cpurst_b  = 1'b0;
    miss_req  = 1'b0;
    vpc       = '0;
    ppc       = '0;
    req_attr  = '0;
    grnt      = 1'b0;
    data_vld  = 1'b0;
    trans_err = 1'b0;
    rdata     = '0;
    chgflw    = 1'b0;
    step(RESET_CYCLES);
    cpurst_b = 1'b1;
    step(1);

    DUT.u_checker.test_name = "full_line";
    start_miss(1'b1);
    bus_response(1'b1, 1'b0);
    send_beats(4, 7);
    end_test();

    DUT.u_checker.test_name = "single_beat";
    start_miss(1'b0);
    bus_response(1'b1, 1'b0);
    send_beats(1, 7);
    end_test();

    DUT.u_checker.test_name = "bus_error";
    start_miss(1'b1);
    bus_response(1'b1, 1'b0);
    send_beats(4, 1);
    end_test();

    DUT.u_checker.test_name = "cancel_in_req";
    start_miss(1'b1);
    bus_response(1'b0, 1'b1);
    end_test();

    DUT.u_checker.test_name = "flow_change_at_grant";
    start_miss(1'b1);
    bus_response(1'b1, 1'b1);
    send_beats(4, 7);
    end_test();

    DUT.u_checker.test_name = "second_full_line";
    start_miss(1'b1);
    bus_response(1'b1, 1'b0);
    send_beats(4, 7);
    end_test();

    $display("tests %0d, failed %0d, errors %0d", test_count, tests_failed, errs_before);
    if (errs_before == 0 && tests_failed == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired before all tests finished");
    $display("TB FAILED");
    $finish;
  end

endmodule

// ==== l1_refill.f ====
logic/l1_refill_pkg.sv
logic/refill_fsm.sv
logic/refill_beat_counter.sv
logic/refill_addr_regs.sv
logic/refill_data_path.sv
logic/l1_refill.sv
bench/l1_refill_checker.sv
bench/tb_l1_refill.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the refill controller testbench with Verilator
rm -f sim.log build.log
verilator --binary --assert --top-module tb_l1_refill -f l1_refill.f -o sim_l1_refill \
  > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_l1_refill +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -qx "TB PASSED" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
